// ==== merge_fsm.sv ====
////////////////////////////////////////
// record sequencing state machine
// side-band and result ready, load strobes
////////////////////////////////////////

`timescale 1ns/1ps

module merge_fsm (
    input  logic                     clk,
    input  logic                     rst,
    input  logic                     s1i_valid,
    input  logic                     s2i_valid,
    input  logic                     s1o_valid,
    input  logic                     s1o_rdy,
    input  logic                     last_tx,
    output logic                     s1i_rdy,
    output logic                     s2i_rdy,
    output logic                     take,
    output logic                     load_query,
    output logic                     load_target,
    output logic                     load_extra,
    output merge_pkg::merge_state_t  state
);

    merge_pkg::merge_state_t next_state;

    // the output register can accept a word this cycle
    logic out_free;

    // states that move one side-band word per take
    logic xfer_state;

    ////////////////////////////////////////
    // handshakes and strobes
    ////////////////////////////////////////

    // the register is free when empty or when its word leaves now
    assign out_free = ~s1o_valid | s1o_rdy;

    // WAIT, INFO_T and LOAD_EXTRA never move side-band data
    assign xfer_state = (state != merge_pkg::WAIT) &&
                        (state != merge_pkg::INFO_T) &&
                        (state != merge_pkg::LOAD_EXTRA);

    assign s2i_rdy = xfer_state & out_free;
    assign take = s2i_valid & s2i_rdy;

    // the result word is released with the last tail word of the record
    assign s1i_rdy = (state == merge_pkg::G_SCORE) & take & s1i_valid;

    // lengths are read from the header that sits on the side-band
    assign load_query = (state == merge_pkg::WAIT);
    assign load_target = (state == merge_pkg::INFO_T);
    assign load_extra = (state == merge_pkg::LOAD_EXTRA);

    ////////////////////////////////////////
    // state register
    ////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= merge_pkg::WAIT;
        end else begin
            state <= next_state;
        end
    end

    ////////////////////////////////////////
    // next state
    ////////////////////////////////////////

    always_comb begin
        next_state = state;
        case (state)
            // start once the result is here and the query header is presented,
            // so that the query length latched in WAIT is a real one
            merge_pkg::WAIT: begin
                if (s1i_valid && s2i_valid) begin
                    next_state = merge_pkg::HEADER_Q;
                end
            end
            // the query header goes out with the local score written into it
            merge_pkg::HEADER_Q: begin
                if (take) begin
                    next_state = merge_pkg::DATA_Q;
                end
            end
            merge_pkg::DATA_Q: begin
                if (take && last_tx) begin
                    next_state = merge_pkg::INFO_T;
                end
            end
            // one cycle to load the target count
            merge_pkg::INFO_T: begin
                next_state = merge_pkg::HEADER_T;
            end
            merge_pkg::HEADER_T: begin
                if (take) begin
                    next_state = merge_pkg::DATA_T;
                end
            end
            merge_pkg::DATA_T: begin
                if (take && last_tx) begin
                    next_state = merge_pkg::LOAD_EXTRA;
                end
            end
            // with no extra words the tail starts right away
            merge_pkg::LOAD_EXTRA: begin
                if (merge_pkg::NUM_EXTRA_TX > 0) begin
                    next_state = merge_pkg::EXTRA;
                end else begin
                    next_state = merge_pkg::Q_BASE;
                end
            end
            merge_pkg::EXTRA: begin
                if (take && last_tx) begin
                    next_state = merge_pkg::Q_BASE;
                end
            end
            // the three merged tail words, one take each
            merge_pkg::Q_BASE: begin
                if (take) begin
                    next_state = merge_pkg::T_BASE;
                end
            end
            merge_pkg::T_BASE: begin
                if (take) begin
                    next_state = merge_pkg::G_SCORE;
                end
            end
            merge_pkg::G_SCORE: begin
                if (take) begin
                    next_state = merge_pkg::WAIT;
                end
            end
            default: begin
                next_state = merge_pkg::WAIT;
            end
        endcase
    end

endmodule

// ==== merge_output.sv ====
////////////////////////////////////////
// merged word formation
// output stream register
////////////////////////////////////////

`timescale 1ns/1ps

module merge_output (
    input  logic                     clk,
    input  logic                     rst,
    input  logic                     take,
    input  logic                     s1o_rdy,
    input  merge_pkg::merge_state_t  state,
    input  merge_pkg::result_word_t  s1i_data,
    input  merge_pkg::data_word_t    s2i_data,
    input  merge_pkg::pos_t          query_len,
    output logic                     s1o_valid,
    output merge_pkg::data_word_t    s1o_data
);

    // result word fields
    merge_pkg::score_t g_score;
    merge_pkg::score_t l_score;
    logic [merge_pkg::T_POS_W-1:0] g_tpos;
    logic [merge_pkg::T_POS_W-1:0] l_tpos;
    logic [merge_pkg::Q_POS_W-1:0] l_qpos;

    merge_pkg::data_word_t next_word;

    assign g_score = s1i_data[merge_pkg::RES_GSCORE_LSB +: merge_pkg::SCORE_W];
    assign g_tpos = s1i_data[merge_pkg::RES_GTPOS_LSB +: merge_pkg::T_POS_W];
    assign l_score = s1i_data[merge_pkg::RES_LSCORE_LSB +: merge_pkg::SCORE_W];
    assign l_tpos = s1i_data[merge_pkg::RES_LTPOS_LSB +: merge_pkg::T_POS_W];
    assign l_qpos = s1i_data[merge_pkg::RES_LQPOS_LSB +: merge_pkg::Q_POS_W];

    ////////////////////////////////////////
    // word for the current state
    ////////////////////////////////////////

    always_comb begin
        next_word = s2i_data;
        case (state)
            // local score above the zero-padded query length
            merge_pkg::HEADER_Q: begin
                next_word = '0;
                next_word[merge_pkg::LEN_FIELD_W +: merge_pkg::SCORE_W] = l_score;
                next_word[merge_pkg::LEN_FIELD_W-1:0] = merge_pkg::LEN_FIELD_W'(query_len);
            end
            // local query end into the upper half, zdrop kept below
            merge_pkg::Q_BASE: begin
                next_word = {merge_pkg::HALF_W'(l_qpos), s2i_data[merge_pkg::HALF_W-1:0]};
            end
            // gtle and tle are replaced, the side-band word is dropped
            merge_pkg::T_BASE: begin
                next_word = {merge_pkg::HALF_W'(g_tpos), merge_pkg::HALF_W'(l_tpos)};
            end
            // max_off kept, global score sign-extended below it
            merge_pkg::G_SCORE: begin
                next_word = {s2i_data[merge_pkg::STREAM_W-1:merge_pkg::HALF_W],
                             {(merge_pkg::HALF_W - merge_pkg::SCORE_W){g_score[merge_pkg::SCORE_W-1]}},
                             g_score};
            end
            default: begin
                next_word = s2i_data;
            end
        endcase
    end

    ////////////////////////////////////////
    // output register
    ////////////////////////////////////////

    // a take refills the register; a departing word without a take empties it
    always_ff @(posedge clk) begin
        if (rst) begin
            s1o_valid <= 1'b0;
        end else if (take) begin
            s1o_valid <= 1'b1;
        end else if (s1o_rdy) begin
            s1o_valid <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (take) begin
            s1o_data <= next_word;
        end
    end

endmodule

// ==== merge_pkg.sv ====
////////////////////////////////////////
// widths, counts and result field offsets
// stream word and field typedefs
// merge state enum
////////////////////////////////////////

package merge_pkg;

    // stream and field widths
    localparam int STREAM_W = 128;
    localparam int HALF_W = STREAM_W / 2;
    localparam int SCORE_W = 9;
    localparam int Q_POS_W = 8;
    localparam int T_POS_W = 10;
    localparam int MAX_POS_W = (Q_POS_W > T_POS_W) ? Q_POS_W : T_POS_W;

    // 2 bits per base, so one word holds 64 bases
    localparam int BASES_PER_TX = 64;
    localparam int LOG_BASES_PER_TX = 6;

    // parameter words copied unchanged ahead of the three merged tail words
    localparam int NUM_EXTRA_TX = 3;

    // zero-padded length field at the bottom of a header word
    localparam int LEN_FIELD_W = 16;

    // result word fields, packed from bit 0 upward
    localparam int RES_GSCORE_LSB = 0;
    localparam int RES_GTPOS_LSB = RES_GSCORE_LSB + SCORE_W;
    localparam int RES_LSCORE_LSB = RES_GTPOS_LSB + T_POS_W;
    localparam int RES_LTPOS_LSB = RES_LSCORE_LSB + SCORE_W;
    localparam int RES_LQPOS_LSB = RES_LTPOS_LSB + T_POS_W;

    typedef logic [STREAM_W-1:0] data_word_t;
    typedef logic [STREAM_W-1:0] result_word_t;
    typedef logic signed [SCORE_W-1:0] score_t;
    typedef logic [MAX_POS_W-1:0] pos_t;
    typedef logic [MAX_POS_W-1:0] tx_count_t;

    // record order, one state per section of the side-band record
    typedef enum logic [3:0] {
        WAIT,
        HEADER_Q,
        DATA_Q,
        INFO_T,
        HEADER_T,
        DATA_T,
        LOAD_EXTRA,
        EXTRA,
        Q_BASE,
        T_BASE,
        G_SCORE
    } merge_state_t;

endpackage

// ==== merge_stream.f ====
merge_pkg.sv
merge_fsm.sv
tx_tracker.sv
merge_output.sv
merge_stream.sv
merge_stream_sva.sv
tb_merge_stream.sv

// ==== merge_stream.sv ====
////////////////////////////////////////
// stream merger top level
// result stream plus side-band record in, merged record out
////////////////////////////////////////

`timescale 1ns/1ps

module merge_stream (
    input  logic                     clk,
    input  logic                     rst,

    // alignment result word, held by the source until s1i_rdy
    input  logic                     s1i_valid,
    output logic                     s1i_rdy,
    input  merge_pkg::result_word_t  s1i_data,

    // side-band record stream
    input  logic                     s2i_valid,
    output logic                     s2i_rdy,
    input  merge_pkg::data_word_t    s2i_data,

    // merged output stream
    output logic                     s1o_valid,
    input  logic                     s1o_rdy,
    output merge_pkg::data_word_t    s1o_data
);

    ////////////////////////////////////////
    // internal wires
    ////////////////////////////////////////

    // a side-band word moves in this cycle
    logic take;

    // count load strobes from the controller
    logic load_query;
    logic load_target;
    logic load_extra;

    // one transfer left in the current section
    logic last_tx;

    merge_pkg::merge_state_t state;
    merge_pkg::pos_t query_len;

    // sequences the record and hands out the ready signals
    merge_fsm fsm_i (
        .clk         (clk),
        .rst         (rst),
        .s1i_valid   (s1i_valid),
        .s2i_valid   (s2i_valid),
        .s1o_valid   (s1o_valid),
        .s1o_rdy     (s1o_rdy),
        .last_tx     (last_tx),
        .s1i_rdy     (s1i_rdy),
        .s2i_rdy     (s2i_rdy),
        .take        (take),
        .load_query  (load_query),
        .load_target (load_target),
        .load_extra  (load_extra),
        .state       (state)
    );

    // section lengths and the transfers left in each
    tx_tracker tracker_i (
        .clk         (clk),
        .rst         (rst),
        .s2i_data    (s2i_data),
        .load_query  (load_query),
        .load_target (load_target),
        .load_extra  (load_extra),
        .take        (take),
        .last_tx     (last_tx),
        .query_len   (query_len)
    );

    // merged word and the output register
    merge_output output_i (
        .clk       (clk),
        .rst       (rst),
        .take      (take),
        .s1o_rdy   (s1o_rdy),
        .state     (state),
        .s1i_data  (s1i_data),
        .s2i_data  (s2i_data),
        .query_len (query_len),
        .s1o_valid (s1o_valid),
        .s1o_data  (s1o_data)
    );

endmodule

// ==== merge_stream_sva.sv ====
////////////////////////////////////////
// bound checker for the stream merger
// record position model and concurrent assertions
////////////////////////////////////////

`timescale 1ns/1ps

module merge_stream_sva (
    input logic                     clk,
    input logic                     rst,
    input logic                     s1i_valid,
    input logic                     s1i_rdy,
    input merge_pkg::result_word_t  s1i_data,
    input logic                     s2i_valid,
    input logic                     s2i_rdy,
    input merge_pkg::data_word_t    s2i_data,
    input logic                     s1o_valid,
    input logic                     s1o_rdy,
    input merge_pkg::data_word_t    s1o_data
);

    // failed checks so far, watched from the testbench top
    int fail_count = 0;

    logic s2_take;
    logic out_xfer;

    // position of the next side-band word in its record
    int in_pos;
    int q_words;
    int t_words;
    int tail_start;
    logic in_last;

    // expected content of the single output register
    merge_pkg::data_word_t exp_word;
    logic exp_pend;
    logic exp_hdr;
    logic exp_tail;
    logic exp_last;
    int exp_total;

    // output words of the current record already sent
    int out_count;

    // last cycle's output, for the back-pressure checks
    logic prev_stall;
    merge_pkg::data_word_t prev_data;

    assign s2_take = s2i_valid & s2i_rdy;
    assign out_xfer = s1o_valid & s1o_rdy;

    // headers, base words and extra words come first, then the three tail words
    assign tail_start = q_words + t_words + 2 + merge_pkg::NUM_EXTRA_TX;
    assign in_last = (in_pos == tail_start + 2);

    function automatic int base_words(input int len);
        return (len + merge_pkg::BASES_PER_TX - 1) / merge_pkg::BASES_PER_TX;
    endfunction

    ////////////////////////////////////////
    // record model
    ////////////////////////////////////////

    // result fields from bit 0 upward: gscore 8:0, gtpos 18:9, lscore 27:19,
    // ltpos 37:28, lqpos 45:38
    always @(posedge clk) begin : track_record
        merge_pkg::data_word_t w;
        int qw_now;
        int tw_now;
        if (rst) begin
            in_pos <= 0;
            q_words <= 0;
            t_words <= 0;
            exp_word <= '0;
            exp_pend <= 1'b0;
            exp_hdr <= 1'b0;
            exp_tail <= 1'b0;
            exp_last <= 1'b0;
            exp_total <= 0;
            out_count <= 0;
            prev_stall <= 1'b0;
            prev_data <= '0;
        end else begin
            if (s2_take) begin
                // section sizes come from the headers as they are accepted
                qw_now = (in_pos == 0) ? base_words(int'(s2i_data[7:0])) : q_words;
                tw_now = (in_pos == qw_now + 1) ? base_words(int'(s2i_data[9:0])) : t_words;
                w = s2i_data;
                exp_hdr <= 1'b0;
                exp_tail <= 1'b0;
                if (in_pos == 0) begin
                    w = '0;
                    w[24:16] = s1i_data[27:19];
                    w[15:0] = {8'h00, s2i_data[7:0]};
                    exp_hdr <= 1'b1;
                end else if (in_pos == tail_start) begin
                    w = {56'h0, s1i_data[45:38], s2i_data[63:0]};
                    exp_tail <= 1'b1;
                end else if (in_pos == tail_start + 1) begin
                    w = {54'h0, s1i_data[18:9], 54'h0, s1i_data[37:28]};
                    exp_tail <= 1'b1;
                end else if (in_last) begin
                    w = {s2i_data[127:64], {55{s1i_data[8]}}, s1i_data[8:0]};
                    exp_tail <= 1'b1;
                end
                exp_word <= w;
                exp_last <= in_last;
                exp_total <= tail_start + 3;
                q_words <= qw_now;
                t_words <= tw_now;
                in_pos <= in_last ? 0 : in_pos + 1;
            end
            if (s2_take) begin
                exp_pend <= 1'b1;
            end else if (out_xfer) begin
                exp_pend <= 1'b0;
            end
            if (out_xfer) begin
                out_count <= exp_last ? 0 : out_count + 1;
            end
            prev_stall <= s1o_valid & ~s1o_rdy;
            prev_data <= s1o_data;
        end
    end

    ////////////////////////////////////////
    // assertions
    ////////////////////////////////////////

    // a stalled output word stays put
    a_stall_valid: assert property (@(posedge clk) disable iff (rst) prev_stall |-> s1o_valid)
    else begin
        $error("mismatch stall_valid expected 1 actual %0d", $sampled(s1o_valid));
        fail_count = fail_count + 1;
    end

    a_stall_data: assert property (@(posedge clk) disable iff (rst)
        prev_stall |-> (s1o_data == prev_data))
    else begin
        $error("mismatch stall_data expected %h actual %h", $sampled(prev_data),
               $sampled(s1o_data));
        fail_count = fail_count + 1;
    end

    a_stall_rdy: assert property (@(posedge clk) disable iff (rst)
        (s1o_valid && !s1o_rdy) |-> !s2i_rdy)
    else begin
        $error("mismatch stall_rdy expected 0 actual %0d", $sampled(s2i_rdy));
        fail_count = fail_count + 1;
    end

    a_query_header: assert property (@(posedge clk) disable iff (rst)
        (out_xfer && exp_hdr) |-> (s1o_data == exp_word))
    else begin
        $error("mismatch query_header expected %h actual %h", $sampled(exp_word),
               $sampled(s1o_data));
        fail_count = fail_count + 1;
    end

    a_copy_word: assert property (@(posedge clk) disable iff (rst)
        (out_xfer && !exp_hdr && !exp_tail) |-> (s1o_data == exp_word))
    else begin
        $error("mismatch copy_word expected %h actual %h", $sampled(exp_word),
               $sampled(s1o_data));
        fail_count = fail_count + 1;
    end

    a_tail_word: assert property (@(posedge clk) disable iff (rst)
        (out_xfer && exp_tail) |-> (s1o_data == exp_word))
    else begin
        $error("mismatch tail_word expected %h actual %h", $sampled(exp_word),
               $sampled(s1o_data));
        fail_count = fail_count + 1;
    end

    a_word_pending: assert property (@(posedge clk) disable iff (rst) out_xfer |-> exp_pend)
    else begin
        $error("an output word appeared with no side-band word accepted for it");
        fail_count = fail_count + 1;
    end

    // the result word is released with the last tail word only
    a_result_rdy: assert property (@(posedge clk) disable iff (rst)
        1'b1 |-> (s1i_rdy == (s2_take && in_last && s1i_valid)))
    else begin
        $error("mismatch result_rdy expected %0d actual %0d",
               $sampled(s2_take && in_last && s1i_valid), $sampled(s1i_rdy));
        fail_count = fail_count + 1;
    end

    a_word_count: assert property (@(posedge clk) disable iff (rst)
        (out_xfer && exp_last) |-> (out_count + 1 == exp_total))
    else begin
        $error("mismatch word_count expected %0d actual %0d", $sampled(exp_total),
               $sampled(out_count) + 1);
        fail_count = fail_count + 1;
    end

endmodule

bind merge_stream merge_stream_sva sva_i (
    .clk       (clk),
    .rst       (rst),
    .s1i_valid (s1i_valid),
    .s1i_rdy   (s1i_rdy),
    .s1i_data  (s1i_data),
    .s2i_valid (s2i_valid),
    .s2i_rdy   (s2i_rdy),
    .s2i_data  (s2i_data),
    .s1o_valid (s1o_valid),
    .s1o_rdy   (s1o_rdy),
    .s1o_data  (s1o_data)
);

// ==== run.sh ====
#!/usr/bin/env bash
# build the stream merger testbench with Verilator, run it, scan the log
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir build.log sim.log
verilator --binary --assert --top-module tb_merge_stream -f merge_stream.f > build.log 2>&1 \
    || { cat build.log; echo "build failed"; exit 1; }
./obj_dir/Vtb_merge_stream +verilator+error+limit+1000 > sim.log 2>&1 \
    || echo "simulation exited with a failing status"
cat sim.log
grep -q "ERRORS FOUND" sim.log && { echo "simulation failed"; exit 1; }
grep -q "NO ERRORS" sim.log || { echo "simulation did not complete"; exit 1; }
echo "simulation passed"

// ==== tb_merge_stream.sv ====
////////////////////////////////////////
// testbench top for the stream merger
// random records, clock, reset, run watchdog
////////////////////////////////////////

`timescale 1ns/1ps

module tb_merge_stream;

    logic clk = 1'b0;
    logic rst = 1'b1;
    logic s1i_valid = 1'b0;
    logic s1i_rdy;
    merge_pkg::result_word_t s1i_data = '0;
    logic s2i_valid = 1'b0;
    logic s2i_rdy;
    merge_pkg::data_word_t s2i_data = '0;
    logic s1o_valid;
    logic s1o_rdy = 1'b0;
    merge_pkg::data_word_t s1o_data;

    // the whole side-band stream, and one result word per record
    merge_pkg::data_word_t side_q[$];
    merge_pkg::result_word_t result_q[$];

    int side_idx = 0;
    int res_idx = 0;
    int rdy_pulses = 0;
    int cycle_count = 0;

    merge_stream dut_i (
        .clk       (clk),
        .rst       (rst),
        .s1i_valid (s1i_valid),
        .s1i_rdy   (s1i_rdy),
        .s1i_data  (s1i_data),
        .s2i_valid (s2i_valid),
        .s2i_rdy   (s2i_rdy),
        .s2i_data  (s2i_data),
        .s1o_valid (s1o_valid),
        .s1o_rdy   (s1o_rdy),
        .s1o_data  (s1o_data)
    );

    always #5 clk = ~clk;

    function automatic merge_pkg::data_word_t rand_word();
        return {$urandom, $urandom, $urandom, $urandom};
    endfunction

    // record number and word index sit in the top bits of a random word
    function automatic merge_pkg::data_word_t tagged_word(input int rec, input int pos);
        merge_pkg::data_word_t w;
        w = rand_word();
        w[127:120] = 8'(rec);
        w[119:104] = 16'(pos);
        return w;
    endfunction

    task automatic build_record(input int rec);
        int qlen;
        int tlen;
        int pos;
        int i;
        merge_pkg::data_word_t w;
        qlen = $urandom_range(200, 1);
        tlen = $urandom_range(900, 1);
        pos = 0;
        // query header, length zero-padded in the low 16 bits
        w = tagged_word(rec, pos);
        w[15:0] = 16'(qlen);
        side_q.push_back(w);
        pos++;
        for (i = 0; i < (qlen + merge_pkg::BASES_PER_TX - 1) / merge_pkg::BASES_PER_TX; i++) begin
            side_q.push_back(tagged_word(rec, pos));
            pos++;
        end
        w = tagged_word(rec, pos);
        w[15:0] = 16'(tlen);
        side_q.push_back(w);
        pos++;
        for (i = 0; i < (tlen + merge_pkg::BASES_PER_TX - 1) / merge_pkg::BASES_PER_TX; i++) begin
            side_q.push_back(tagged_word(rec, pos));
            pos++;
        end
        // extra words, then zdrop, gtle/tle and max_off/gscore
        for (i = 0; i < merge_pkg::NUM_EXTRA_TX + 3; i++) begin
            side_q.push_back(tagged_word(rec, pos));
            pos++;
        end
        result_q.push_back(rand_word());
    endtask

    ////////////////////////////////////////
    // stream sources and output sink
    ////////////////////////////////////////

    // a source holds its word until the handshake, then may pause
    always @(posedge clk) begin : drive_streams
        logic side_done;
        logic res_done;
        if (rst) begin
            s1i_valid <= 1'b0;
            s2i_valid <= 1'b0;
            s1o_rdy <= 1'b0;
        end else begin
            side_done = s2i_valid && s2i_rdy;
            res_done = s1i_valid && s1i_rdy;
            if (side_done) begin
                side_idx = side_idx + 1;
            end
            if (res_done) begin
                res_idx = res_idx + 1;
                rdy_pulses = rdy_pulses + 1;
            end
            if (!s2i_valid || side_done) begin
                if (side_idx < side_q.size() && $urandom_range(3, 0) != 0) begin
                    s2i_valid <= 1'b1;
                    s2i_data <= side_q[side_idx];
                end else begin
                    // idle cycles show junk on the data lines
                    s2i_valid <= 1'b0;
                    s2i_data <= rand_word();
                end
            end
            if (!s1i_valid || res_done) begin
                if (res_idx < result_q.size() && $urandom_range(1, 0) != 0) begin
                    s1i_valid <= 1'b1;
                    s1i_data <= result_q[res_idx];
                end else begin
                    s1i_valid <= 1'b0;
                end
            end
            s1o_rdy <= ($urandom_range(2, 0) != 0);
        end
    end

    // 8 records of at most 27 words each finish far inside 20000 cycles
    always @(negedge clk) begin : watch_run
        cycle_count <= cycle_count + 1;
        if (dut_i.sva_i.fail_count != 0) begin
            $display("ERRORS FOUND");
            $fatal(1, "a checker assertion failed");
        end else if (cycle_count >= 20000) begin
            $display("run timed out after %0d cycles", cycle_count);
            $display("ERRORS FOUND");
            $fatal(1, "timeout");
        end
    end

    initial begin : run_test
        int rec;
        void'($urandom(32'heb30_ccf6));
        for (rec = 0; rec < 8; rec++) begin
            build_record(rec);
        end
        repeat (16) @(posedge clk);
        rst <= 1'b0;
        wait (rdy_pulses == 8);
        // the last tail word still has to leave the output register
        @(negedge clk);
        while (s1o_valid) begin
            @(negedge clk);
        end
        repeat (2) @(negedge clk);
        if (dut_i.sva_i.fail_count == 0) begin
            $display("NO ERRORS");
            $finish;
        end else begin
            $display("ERRORS FOUND");
            $fatal(1, "checker failures at the end of the run");
        end
    end

endmodule

// ==== tx_tracker.sv ====
////////////////////////////////////////
// section transfer counter
// latched query length
////////////////////////////////////////

`timescale 1ns/1ps

module tx_tracker (
    input  logic                   clk,
    input  logic                   rst,
    input  merge_pkg::data_word_t  s2i_data,
    input  logic                   load_query,
    input  logic                   load_target,
    input  logic                   load_extra,
    input  logic                   take,
    output logic                   last_tx,
    output merge_pkg::pos_t        query_len
);

    // number of base words for a length, rounded up to whole words
    function automatic merge_pkg::tx_count_t words_of(input merge_pkg::pos_t len);
        logic [merge_pkg::MAX_POS_W:0] sum;
        sum = {1'b0, len} + (merge_pkg::MAX_POS_W + 1)'(merge_pkg::BASES_PER_TX - 1);
        return merge_pkg::tx_count_t'(sum >> merge_pkg::LOG_BASES_PER_TX);
    endfunction

    merge_pkg::pos_t q_len_in;
    merge_pkg::pos_t t_len_in;
    merge_pkg::tx_count_t tx_left;

    // set between the target load and the target header take
    logic t_hdr_pend;

    assign q_len_in = merge_pkg::pos_t'(s2i_data[merge_pkg::Q_POS_W-1:0]);
    assign t_len_in = merge_pkg::pos_t'(s2i_data[merge_pkg::T_POS_W-1:0]);

    // a section count covers its header word plus the base words
    always_ff @(posedge clk) begin
        if (rst) begin
            tx_left <= '0;
            t_hdr_pend <= 1'b0;
        end else if (load_query) begin
            tx_left <= words_of(q_len_in) + merge_pkg::tx_count_t'(1);
        end else if (load_target) begin
            tx_left <= words_of(t_len_in) + merge_pkg::tx_count_t'(1);
            t_hdr_pend <= 1'b1;
        end else if (load_extra) begin
            tx_left <= merge_pkg::tx_count_t'(merge_pkg::NUM_EXTRA_TX);
        end else if (take) begin
            // the target header may show up after INFO_T, so the base count
            // is taken again from the header that actually moved
            if (t_hdr_pend) begin
                tx_left <= words_of(t_len_in);
            end else begin
                tx_left <= tx_left - merge_pkg::tx_count_t'(1);
            end
            t_hdr_pend <= 1'b0;
        end
    end

    // query length for the rewritten query header
    always_ff @(posedge clk) begin
        if (load_query) begin
            query_len <= q_len_in;
        end
    end

    assign last_tx = (tx_left == merge_pkg::tx_count_t'(1));

endmodule
